// ==== design/soc_pkg.sv ====
package soc_pkg;

    // System bus
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int DATA_BYTES = DATA_W / 8;

    // L1 array geometry
    localparam int L1_WAYS = 2;
    localparam int L1_ROWS = 64;
    localparam int ROW_W   = $clog2(L1_ROWS);
    localparam int TAG_W   = 20;
    localparam int BLOCK_W = 128;

    // Read command to read valid, at least 1
    localparam int L1_LATENCY = 2;

    // Address windows, bits outside the mask select the window
    localparam logic [ADDR_W-1:0] RAM_BASE  = 32'h4000_0000;
    localparam logic [ADDR_W-1:0] RAM_MASK  = 32'h000F_FFFF;
    localparam logic [ADDR_W-1:0] SPI_BASE  = 32'h2001_0000;
    localparam logic [ADDR_W-1:0] SPI_MASK  = 32'h0000_00FF;
    localparam logic [ADDR_W-1:0] UART_BASE = 32'h2000_0000;
    localparam logic [ADDR_W-1:0] UART_MASK = 32'h0000_00FF;

    function automatic logic in_window(
        input logic [ADDR_W-1:0] addr,
        input logic [ADDR_W-1:0] base,
        input logic [ADDR_W-1:0] mask
    );
        return (addr & ~mask) == base;
    endfunction

endpackage

// ==== design/bram_port_if.sv ====
`timescale 1ns/1ps

interface bram_port_if #(
    parameter int WIDTH = 32
);

    logic                      en;
    logic                      we;
    logic [soc_pkg::ROW_W-1:0] addr;
    logic [WIDTH-1:0]          wdata;
    logic [WIDTH-1:0]          rdata;

    // Array side issues commands
    modport client (
        output en, we, addr, wdata,
        input  rdata
    );

    modport memory (
        input  en, we, addr, wdata,
        output rdata
    );

endinterface

// ==== design/bram_model.sv ====
`timescale 1ns/1ps

module bram_model #(
    parameter int DEPTH = 64
) (
    input logic         clk,
    bram_port_if.memory port_i
);

    logic [$bits(port_i.wdata)-1:0] mem [DEPTH];

    // Read port is registered and holds its value between commands
    always_ff @(posedge clk) begin
        if (port_i.en) begin
            if (port_i.we) begin
                mem[port_i.addr] <= port_i.wdata;
            end else begin
                port_i.rdata <= mem[port_i.addr];
            end
        end
    end

endmodule

// ==== design/l1_array.sv ====
`timescale 1ns/1ps

module l1_array (
    input  logic                                          clk,
    input  logic                                          resetn,
    input  logic                                          l1_cmd_en_i,
    input  logic [soc_pkg::ROW_W-1:0]                     l1_cmd_row_i,
    input  logic [soc_pkg::L1_WAYS-1:0]                   l1_cmd_wr_i,
    input  logic [soc_pkg::L1_WAYS*soc_pkg::TAG_W-1:0]    l1_cmd_tag_i,
    input  logic [soc_pkg::L1_WAYS*soc_pkg::BLOCK_W-1:0]  l1_cmd_block_i,
    output logic [soc_pkg::L1_WAYS*soc_pkg::TAG_W-1:0]    l1_rd_tag_o,
    output logic [soc_pkg::L1_WAYS*soc_pkg::BLOCK_W-1:0]  l1_rd_block_o,
    output logic                                          l1_rd_valid_o
);

    logic                                         rd_issue;
    logic [soc_pkg::L1_LATENCY-1:0]               rd_pipe;
    logic [soc_pkg::L1_WAYS*soc_pkg::TAG_W-1:0]   rd_tag_w;
    logic [soc_pkg::L1_WAYS*soc_pkg::BLOCK_W-1:0] rd_block_w;

    assign rd_issue = l1_cmd_en_i && (l1_cmd_wr_i == '0);

    for (genvar w = 0; w < soc_pkg::L1_WAYS; w++) begin : g_way
        bram_port_if #(.WIDTH(soc_pkg::TAG_W))   tag_port ();
        bram_port_if #(.WIDTH(soc_pkg::BLOCK_W)) block_port ();

        // Ways not selected by the write mask do a harmless read
        assign tag_port.en    = l1_cmd_en_i;
        assign tag_port.we    = l1_cmd_wr_i[w];
        assign tag_port.addr  = l1_cmd_row_i;
        assign tag_port.wdata = l1_cmd_tag_i[w*soc_pkg::TAG_W +: soc_pkg::TAG_W];

        assign block_port.en    = l1_cmd_en_i;
        assign block_port.we    = l1_cmd_wr_i[w];
        assign block_port.addr  = l1_cmd_row_i;
        assign block_port.wdata = l1_cmd_block_i[w*soc_pkg::BLOCK_W +: soc_pkg::BLOCK_W];

        bram_model #(.DEPTH(soc_pkg::L1_ROWS)) u_tag (
            .clk    (clk),
            .port_i (tag_port.memory)
        );

        bram_model #(.DEPTH(soc_pkg::L1_ROWS)) u_block (
            .clk    (clk),
            .port_i (block_port.memory)
        );

        assign rd_tag_w[w*soc_pkg::TAG_W +: soc_pkg::TAG_W]       = tag_port.rdata;
        assign rd_block_w[w*soc_pkg::BLOCK_W +: soc_pkg::BLOCK_W] = block_port.rdata;
    end

    // Read valid delay line
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_pipe <= '0;
        end else begin
            rd_pipe    <= rd_pipe << 1;
            rd_pipe[0] <= rd_issue;
        end
    end

    assign l1_rd_valid_o = rd_pipe[soc_pkg::L1_LATENCY-1];

    // RAM output is one cycle late, remaining stages keep data next to valid
    if (soc_pkg::L1_LATENCY > 1) begin : g_stage
        logic [soc_pkg::L1_WAYS*soc_pkg::TAG_W-1:0]   tag_pipe   [soc_pkg::L1_LATENCY-1];
        logic [soc_pkg::L1_WAYS*soc_pkg::BLOCK_W-1:0] block_pipe [soc_pkg::L1_LATENCY-1];

        always_ff @(posedge clk) begin
            tag_pipe[0]   <= rd_tag_w;
            block_pipe[0] <= rd_block_w;
            for (int s = 1; s < soc_pkg::L1_LATENCY - 1; s++) begin
                tag_pipe[s]   <= tag_pipe[s-1];
                block_pipe[s] <= block_pipe[s-1];
            end
        end

        assign l1_rd_tag_o   = tag_pipe[soc_pkg::L1_LATENCY-2];
        assign l1_rd_block_o = block_pipe[soc_pkg::L1_LATENCY-2];
    end else begin : g_direct
        assign l1_rd_tag_o   = rd_tag_w;
        assign l1_rd_block_o = rd_block_w;
    end

    assert property (@(posedge clk) disable iff (!resetn)
        l1_cmd_en_i |-> !$isunknown(l1_cmd_wr_i))
        else $error("l1_array: undefined way mask on a command");

endmodule

// ==== design/mem_fabric.sv ====
`timescale 1ns/1ps

module mem_fabric (
    input  logic                           clk,
    input  logic                           resetn,

    input  logic [soc_pkg::ADDR_W-1:0]     mem_req_addr_i,
    input  logic [soc_pkg::DATA_W-1:0]     mem_req_wdata_i,
    input  logic                           mem_req_write_i,
    input  logic                           mem_req_valid_i,
    output logic                           mem_req_ready_o,
    output logic [soc_pkg::DATA_W-1:0]     mem_rsp_data_o,
    output logic                           mem_rsp_valid_o,

    output logic                           iomem_valid_o,
    input  logic                           iomem_ready_i,
    output logic [soc_pkg::DATA_BYTES-1:0] iomem_wstrb_o,
    output logic [soc_pkg::ADDR_W-1:0]     iomem_addr_o,
    output logic [soc_pkg::DATA_W-1:0]     iomem_wdata_o,
    input  logic [soc_pkg::DATA_W-1:0]     iomem_rdata_i,

    input  logic                           spi_ready_i,
    input  logic [soc_pkg::DATA_W-1:0]     spi_rsp_data_i,
    input  logic                           spi_rsp_valid_i,

    input  logic                           uart_ready_i,
    input  logic [soc_pkg::DATA_W-1:0]     uart_rsp_data_i,
    input  logic                           uart_rsp_valid_i
);

    logic ram_hit;
    logic spi_hit;
    logic uart_hit;
    logic req_idle;
    logic rd_pending;
    logic rd_active;

    // Shared bus, peripherals decode for themselves
    assign iomem_valid_o = mem_req_valid_i;
    assign iomem_addr_o  = mem_req_addr_i;
    assign iomem_wdata_o = mem_req_wdata_i;
    assign iomem_wstrb_o = {soc_pkg::DATA_BYTES{mem_req_write_i}};

    assign ram_hit  = soc_pkg::in_window(mem_req_addr_i, soc_pkg::RAM_BASE, soc_pkg::RAM_MASK);
    assign spi_hit  = soc_pkg::in_window(mem_req_addr_i, soc_pkg::SPI_BASE, soc_pkg::SPI_MASK);
    assign uart_hit = soc_pkg::in_window(mem_req_addr_i, soc_pkg::UART_BASE, soc_pkg::UART_MASK);

    // Unmapped addresses never see ready
    assign mem_req_ready_o = ram_hit  ? iomem_ready_i :
                             spi_hit  ? spi_ready_i   :
                             uart_hit ? uart_ready_i  : 1'b0;

    // Outstanding request tracker
    always_ff @(posedge clk) begin
        if (!resetn) begin
            req_idle   <= 1'b1;
            rd_pending <= 1'b0;
        end else begin
            if (req_idle && mem_req_valid_i) begin
                req_idle   <= 1'b0;
                rd_pending <= !mem_req_write_i;
            end
            if (mem_req_ready_o) begin
                req_idle   <= 1'b1;
                rd_pending <= 1'b0;
            end
        end
    end

    // Covers a RAM read that completes on its first cycle
    assign rd_active = req_idle ? (mem_req_valid_i && !mem_req_write_i) : rd_pending;

    // Fixed priority RAM, then SPI, then UART
    always_comb begin
        mem_rsp_data_o  = '0;
        mem_rsp_valid_o = 1'b0;
        if (rd_active && iomem_ready_i) begin
            mem_rsp_data_o  = iomem_rdata_i;
            mem_rsp_valid_o = 1'b1;
        end else if (spi_rsp_valid_i) begin
            mem_rsp_data_o  = spi_rsp_data_i;
            mem_rsp_valid_o = 1'b1;
        end else if (uart_rsp_valid_i) begin
            mem_rsp_data_o  = uart_rsp_data_i;
            mem_rsp_valid_o = 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!resetn)
        mem_req_valid_i && !mem_req_ready_o |=> mem_req_valid_i)
        else $error("mem_fabric: request withdrawn before ready");

    assert property (@(posedge clk) disable iff (!resetn)
        mem_req_valid_i && !mem_req_ready_o |=> $stable(mem_req_addr_i))
        else $error("mem_fabric: address changed while waiting");

endmodule

// ==== design/soc_glue_top.sv ====
`timescale 1ns/1ps

module soc_glue_top (
    input  logic                                          clk,
    input  logic                                          resetn,

    input  logic                                          l1_cmd_en_i,
    input  logic [soc_pkg::ROW_W-1:0]                     l1_cmd_row_i,
    input  logic [soc_pkg::L1_WAYS-1:0]                   l1_cmd_wr_i,
    input  logic [soc_pkg::L1_WAYS*soc_pkg::TAG_W-1:0]    l1_cmd_tag_i,
    input  logic [soc_pkg::L1_WAYS*soc_pkg::BLOCK_W-1:0]  l1_cmd_block_i,
    output logic [soc_pkg::L1_WAYS*soc_pkg::TAG_W-1:0]    l1_rd_tag_o,
    output logic [soc_pkg::L1_WAYS*soc_pkg::BLOCK_W-1:0]  l1_rd_block_o,
    output logic                                          l1_rd_valid_o,

    input  logic [soc_pkg::ADDR_W-1:0]                    mem_req_addr_i,
    input  logic [soc_pkg::DATA_W-1:0]                    mem_req_wdata_i,
    input  logic                                          mem_req_write_i,
    input  logic                                          mem_req_valid_i,
    output logic                                          mem_req_ready_o,
    output logic [soc_pkg::DATA_W-1:0]                    mem_rsp_data_o,
    output logic                                          mem_rsp_valid_o,

    output logic                                          iomem_valid_o,
    input  logic                                          iomem_ready_i,
    output logic [soc_pkg::DATA_BYTES-1:0]                iomem_wstrb_o,
    output logic [soc_pkg::ADDR_W-1:0]                    iomem_addr_o,
    output logic [soc_pkg::DATA_W-1:0]                    iomem_wdata_o,
    input  logic [soc_pkg::DATA_W-1:0]                    iomem_rdata_i,

    input  logic                                          spi_ready_i,
    input  logic [soc_pkg::DATA_W-1:0]                    spi_rsp_data_i,
    input  logic                                          spi_rsp_valid_i,

    input  logic                                          uart_ready_i,
    input  logic [soc_pkg::DATA_W-1:0]                    uart_rsp_data_i,
    input  logic                                          uart_rsp_valid_i
);

    // One bank serves both instruction and data sides
    l1_array u_l1_array (
        .clk            (clk),
        .resetn         (resetn),
        .l1_cmd_en_i    (l1_cmd_en_i),
        .l1_cmd_row_i   (l1_cmd_row_i),
        .l1_cmd_wr_i    (l1_cmd_wr_i),
        .l1_cmd_tag_i   (l1_cmd_tag_i),
        .l1_cmd_block_i (l1_cmd_block_i),
        .l1_rd_tag_o    (l1_rd_tag_o),
        .l1_rd_block_o  (l1_rd_block_o),
        .l1_rd_valid_o  (l1_rd_valid_o)
    );

    mem_fabric u_mem_fabric (
        .clk              (clk),
        .resetn           (resetn),
        .mem_req_addr_i   (mem_req_addr_i),
        .mem_req_wdata_i  (mem_req_wdata_i),
        .mem_req_write_i  (mem_req_write_i),
        .mem_req_valid_i  (mem_req_valid_i),
        .mem_req_ready_o  (mem_req_ready_o),
        .mem_rsp_data_o   (mem_rsp_data_o),
        .mem_rsp_valid_o  (mem_rsp_valid_o),
        .iomem_valid_o    (iomem_valid_o),
        .iomem_ready_i    (iomem_ready_i),
        .iomem_wstrb_o    (iomem_wstrb_o),
        .iomem_addr_o     (iomem_addr_o),
        .iomem_wdata_o    (iomem_wdata_o),
        .iomem_rdata_i    (iomem_rdata_i),
        .spi_ready_i      (spi_ready_i),
        .spi_rsp_data_i   (spi_rsp_data_i),
        .spi_rsp_valid_i  (spi_rsp_valid_i),
        .uart_ready_i     (uart_ready_i),
        .uart_rsp_data_i  (uart_rsp_data_i),
        .uart_rsp_valid_i (uart_rsp_valid_i)
    );

endmodule

// ==== tests/soc_glue_tb.sv ====
`timescale 1ns/1ps

module soc_glue_tb;

    localparam int TIMEOUT = 64;
    localparam int TW = soc_pkg::L1_WAYS * soc_pkg::TAG_W;
    localparam int BW = soc_pkg::L1_WAYS * soc_pkg::BLOCK_W;

    typedef logic [BW-1:0] wide_t;

    logic clk = 1'b0;
    logic resetn;
    logic l1_cmd_en_i, l1_rd_valid_o;
    logic [soc_pkg::ROW_W-1:0] l1_cmd_row_i;
    logic [soc_pkg::L1_WAYS-1:0] l1_cmd_wr_i;
    logic [TW-1:0] l1_cmd_tag_i, l1_rd_tag_o;
    logic [BW-1:0] l1_cmd_block_i, l1_rd_block_o;
    logic [soc_pkg::ADDR_W-1:0] mem_req_addr_i, iomem_addr_o;
    logic [soc_pkg::DATA_W-1:0] mem_req_wdata_i, mem_rsp_data_o, iomem_wdata_o, iomem_rdata_i;
    logic [soc_pkg::DATA_W-1:0] spi_rsp_data_i, uart_rsp_data_i;
    logic mem_req_write_i, mem_req_valid_i, mem_req_ready_o, mem_rsp_valid_o;
    logic iomem_valid_o, iomem_ready_i, spi_ready_i, spi_rsp_valid_i;
    logic uart_ready_i, uart_rsp_valid_i;
    logic [soc_pkg::DATA_BYTES-1:0] iomem_wstrb_o;

    // Reference state
    logic [soc_pkg::TAG_W-1:0] shadow_tag [soc_pkg::L1_WAYS][soc_pkg::L1_ROWS];
    logic [soc_pkg::BLOCK_W-1:0] shadow_block [soc_pkg::L1_WAYS][soc_pkg::L1_ROWS];
    logic [TW-1:0] exp_tag_q [$];
    logic [BW-1:0] exp_block_q [$];
    int exp_cycle_q [$];
    int cycle;
    int errors = 0;
    int timeouts = 0;
    logic exp_l1_valid;
    logic [TW-1:0] exp_l1_tag;
    logic [BW-1:0] exp_l1_block;
    logic trk_idle, trk_read, exp_ready, exp_rsp_valid;
    logic [soc_pkg::DATA_W-1:0] exp_rsp_data;
    logic [soc_pkg::DATA_BYTES-1:0] exp_wstrb;
    logic [soc_pkg::ROW_W-1:0] rows [8];
    logic [31:0] rnd;

    soc_glue_top soc_glue_top_i (.*);

    always #2 clk = ~clk;

    function automatic logic window_match(input logic [soc_pkg::ADDR_W-1:0] addr, base, mask);
        return (addr | mask) == (base | mask);
    endfunction

    task automatic report_mismatch(input string name, input wide_t expected, input wide_t actual);
        errors++;
        $display("FAIL %0t %s expected %0h actual %0h", $time, name, expected, actual);
    endtask

    // L1 reference: shadow contents and reads in flight
    always @(posedge clk) begin
        logic [TW-1:0] rd_tag;
        logic [BW-1:0] rd_block;
        if (!resetn) begin
            cycle = 0;
            exp_cycle_q.delete();
            exp_tag_q.delete();
            exp_block_q.delete();
            exp_l1_valid <= 1'b0;
        end else begin
            cycle = cycle + 1;
            if (l1_cmd_en_i) begin
                for (int w = 0; w < soc_pkg::L1_WAYS; w++) begin
                    if (l1_cmd_wr_i[w]) begin
                        shadow_tag[w][l1_cmd_row_i] =
                            l1_cmd_tag_i[w*soc_pkg::TAG_W +: soc_pkg::TAG_W];
                        shadow_block[w][l1_cmd_row_i] =
                            l1_cmd_block_i[w*soc_pkg::BLOCK_W +: soc_pkg::BLOCK_W];
                    end
                    rd_tag[w*soc_pkg::TAG_W +: soc_pkg::TAG_W] = shadow_tag[w][l1_cmd_row_i];
                    rd_block[w*soc_pkg::BLOCK_W +: soc_pkg::BLOCK_W] =
                        shadow_block[w][l1_cmd_row_i];
                end
                if (l1_cmd_wr_i == '0) begin
                    exp_cycle_q.push_back(cycle);
                    exp_tag_q.push_back(rd_tag);
                    exp_block_q.push_back(rd_block);
                end
            end
            // Expected values land one edge before the edge that checks them
            exp_l1_valid <= 1'b0;
            if (exp_cycle_q.size() > 0 &&
                    exp_cycle_q[0] + soc_pkg::L1_LATENCY - 1 == cycle) begin
                void'(exp_cycle_q.pop_front());
                exp_l1_valid <= 1'b1;
                exp_l1_tag   <= exp_tag_q.pop_front();
                exp_l1_block <= exp_block_q.pop_front();
            end
        end
    end

    // Fabric reference
    always @(posedge clk) begin
        if (!resetn || exp_ready) begin
            trk_idle <= 1'b1;
            trk_read <= 1'b0;
        end else if (trk_idle && mem_req_valid_i) begin
            trk_idle <= 1'b0;
            trk_read <= !mem_req_write_i;
        end
    end

    always_comb begin
        exp_ready = 1'b0;
        if (window_match(mem_req_addr_i, soc_pkg::RAM_BASE, soc_pkg::RAM_MASK))
            exp_ready = iomem_ready_i;
        else if (window_match(mem_req_addr_i, soc_pkg::SPI_BASE, soc_pkg::SPI_MASK))
            exp_ready = spi_ready_i;
        else if (window_match(mem_req_addr_i, soc_pkg::UART_BASE, soc_pkg::UART_MASK))
            exp_ready = uart_ready_i;
        exp_wstrb = mem_req_write_i ? '1 : '0;
        exp_rsp_valid = 1'b1;
        exp_rsp_data = '0;
        if ((trk_read || (trk_idle && mem_req_valid_i && !mem_req_write_i)) && iomem_ready_i)
            exp_rsp_data = iomem_rdata_i;
        else if (spi_rsp_valid_i)
            exp_rsp_data = spi_rsp_data_i;
        else if (uart_rsp_valid_i)
            exp_rsp_data = uart_rsp_data_i;
        else
            exp_rsp_valid = 1'b0;
    end

    assert property (@(posedge clk) disable iff (!resetn)
        l1_rd_valid_o == exp_l1_valid)
        else report_mismatch("l1_rd_valid_o", wide_t'(exp_l1_valid),
                             wide_t'($sampled(l1_rd_valid_o)));
    assert property (@(posedge clk) disable iff (!resetn)
        exp_l1_valid |-> l1_rd_tag_o == exp_l1_tag)
        else report_mismatch("l1_rd_tag_o", wide_t'(exp_l1_tag),
                             wide_t'($sampled(l1_rd_tag_o)));
    assert property (@(posedge clk) disable iff (!resetn)
        exp_l1_valid |-> l1_rd_block_o == exp_l1_block)
        else report_mismatch("l1_rd_block_o", exp_l1_block, $sampled(l1_rd_block_o));
    assert property (@(posedge clk) disable iff (!resetn)
        mem_req_ready_o == exp_ready)
        else report_mismatch("mem_req_ready_o", wide_t'(exp_ready),
                             wide_t'($sampled(mem_req_ready_o)));
    assert property (@(posedge clk) disable iff (!resetn)
        iomem_wstrb_o == exp_wstrb)
        else report_mismatch("iomem_wstrb_o", wide_t'(exp_wstrb),
                             wide_t'($sampled(iomem_wstrb_o)));
    assert property (@(posedge clk) disable iff (!resetn)
        iomem_valid_o == mem_req_valid_i)
        else report_mismatch("iomem_valid_o", wide_t'(mem_req_valid_i),
                             wide_t'($sampled(iomem_valid_o)));
    assert property (@(posedge clk) disable iff (!resetn)
        iomem_addr_o == mem_req_addr_i)
        else report_mismatch("iomem_addr_o", wide_t'(mem_req_addr_i),
                             wide_t'($sampled(iomem_addr_o)));
    assert property (@(posedge clk) disable iff (!resetn)
        iomem_wdata_o == mem_req_wdata_i)
        else report_mismatch("iomem_wdata_o", wide_t'(mem_req_wdata_i),
                             wide_t'($sampled(iomem_wdata_o)));
    assert property (@(posedge clk) disable iff (!resetn)
        mem_rsp_valid_o == exp_rsp_valid)
        else report_mismatch("mem_rsp_valid_o", wide_t'(exp_rsp_valid),
                             wide_t'($sampled(mem_rsp_valid_o)));
    assert property (@(posedge clk) disable iff (!resetn)
        mem_rsp_data_o == exp_rsp_data)
        else report_mismatch("mem_rsp_data_o", wide_t'(exp_rsp_data),
                             wide_t'($sampled(mem_rsp_data_o)));

    task automatic bus_idle();
        mem_req_addr_i = '0;
        mem_req_wdata_i = '0;
        mem_req_write_i = 1'b0;
        mem_req_valid_i = 1'b0;
        iomem_ready_i = 1'b0;
        iomem_rdata_i = '0;
        spi_ready_i = 1'b0;
        spi_rsp_valid_i = 1'b0;
        spi_rsp_data_i = '0;
        uart_ready_i = 1'b0;
        uart_rsp_valid_i = 1'b0;
        uart_rsp_data_i = '0;
    endtask

    task automatic l1_write(input logic [soc_pkg::ROW_W-1:0] row,
                            input logic [soc_pkg::L1_WAYS-1:0] mask);
        logic [31:0] r;
        l1_cmd_en_i = 1'b1;
        l1_cmd_row_i = row;
        l1_cmd_wr_i = (mask == '0) ? '1 : mask;
        for (int w = 0; w < soc_pkg::L1_WAYS; w++) begin
            r = $urandom;
            l1_cmd_tag_i[w*soc_pkg::TAG_W +: soc_pkg::TAG_W] = r[soc_pkg::TAG_W-1:0];
        end
        for (int k = 0; k < BW / 32; k++)
            l1_cmd_block_i[k*32 +: 32] = $urandom;
        @(negedge clk);
        l1_cmd_en_i = 1'b0;
        l1_cmd_wr_i = '0;
    endtask

    // Consecutive calls give back-to-back reads
    task automatic l1_read(input logic [soc_pkg::ROW_W-1:0] row);
        l1_cmd_en_i = 1'b1;
        l1_cmd_wr_i = '0;
        l1_cmd_row_i = row;
        @(negedge clk);
        l1_cmd_en_i = 1'b0;
    endtask

    task automatic l1_drain();
        int n;
        for (n = 0; n < TIMEOUT && exp_cycle_q.size() > 0; n++)
            @(negedge clk);
        if (exp_cycle_q.size() > 0) begin
            timeouts++;
            $display("Timeout: L1 reads still outstanding at %0t", $time);
        end
    endtask

    // sel picks the window whose ready completes the request
    task automatic mem_access(input logic [soc_pkg::ADDR_W-1:0] base, mask,
                              input logic write, input int sel);
        logic [31:0] r;
        int delay;
        int n;
        r = $urandom;
        delay = $urandom % 4;
        mem_req_addr_i = base | (r & mask);
        mem_req_wdata_i = $urandom;
        mem_req_write_i = write;
        mem_req_valid_i = 1'b1;
        iomem_rdata_i = $urandom;
        for (n = 0; n < TIMEOUT; n++) begin
            r = $urandom;
            iomem_ready_i = (sel == 0) ? (n >= delay) : r[0];
            spi_ready_i = (sel == 1) ? (n >= delay) : r[1];
            uart_ready_i = (sel == 2) ? (n >= delay) : r[2];
            @(posedge clk);
            if (mem_req_ready_o)
                break;
            @(negedge clk);
        end
        if (n == TIMEOUT) begin
            timeouts++;
            $display("Timeout: request to %h was never accepted", mem_req_addr_i);
        end
        @(negedge clk);
        bus_idle();
    endtask

    task automatic rsp_pulse(input logic spi_v, input logic uart_v);
        spi_rsp_valid_i = spi_v;
        spi_rsp_data_i = $urandom;
        uart_rsp_valid_i = uart_v;
        uart_rsp_data_i = $urandom;
        @(negedge clk);
        bus_idle();
    endtask

    initial begin
        void'($urandom(84));
        resetn = 1'b0;
        l1_cmd_en_i = 1'b0;
        l1_cmd_row_i = '0;
        l1_cmd_wr_i = '0;
        l1_cmd_tag_i = '0;
        l1_cmd_block_i = '0;
        bus_idle();
        repeat (4) @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);

        rnd = $urandom;
        for (int i = 0; i < 8; i++) begin
            rnd = rnd + 32'd9;
            rows[i] = rnd[soc_pkg::ROW_W-1:0];
            l1_write(rows[i], '1);
        end
        // Partial way updates on half the rows
        for (int i = 0; i < 8; i += 2) begin
            rnd = $urandom;
            l1_write(rows[i], rnd[soc_pkg::L1_WAYS-1:0]);
        end
        for (int i = 0; i < 8; i++) begin
            l1_read(rows[i]);
            l1_drain();
        end
        for (int i = 7; i >= 0; i--)
            l1_read(rows[i]);
        l1_drain();

        mem_access(soc_pkg::RAM_BASE, soc_pkg::RAM_MASK, 1'b1, 0);
        mem_access(soc_pkg::RAM_BASE, soc_pkg::RAM_MASK, 1'b0, 0);
        mem_access(soc_pkg::SPI_BASE, soc_pkg::SPI_MASK, 1'b1, 1);
        mem_access(soc_pkg::SPI_BASE, soc_pkg::SPI_MASK, 1'b0, 1);
        mem_access(soc_pkg::UART_BASE, soc_pkg::UART_MASK, 1'b1, 2);
        mem_access(soc_pkg::UART_BASE, soc_pkg::UART_MASK, 1'b0, 2);
        rsp_pulse(1'b1, 1'b1);
        rsp_pulse(1'b0, 1'b1);
        rsp_pulse(1'b1, 1'b0);

        // Unmapped request never completes, reset clears it
        mem_req_addr_i = 32'h1000_0040;
        mem_req_valid_i = 1'b1;
        iomem_ready_i = 1'b1;
        spi_ready_i = 1'b1;
        uart_ready_i = 1'b1;
        repeat (20) @(negedge clk);
        resetn = 1'b0;
        @(negedge clk);
        bus_idle();
        repeat (3) @(negedge clk);
        resetn = 1'b1;
        repeat (4) @(negedge clk);

        $display("errors %0d timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== soc_glue_top.f ====
design/soc_pkg.sv
design/bram_port_if.sv
design/bram_model.sv
design/l1_array.sv
design/mem_fabric.sv
design/soc_glue_top.sv
tests/soc_glue_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module soc_glue_tb -f soc_glue_top.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vsoc_glue_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
